//--- Bender.yml
package:
  name: aes_128_core

sources:
  - common/aes_pkg.sv
  - src/aes_sub_word.sv
  - cipher_round/aes_ttable_column.sv
  - cipher_round/aes_round.sv
  - cipher_round/aes_final_round.sv
  - key_schedule/aes_key_expand.sv
  - src/aes_128_core.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/aes_128_tb.sv

//--- cipher_round/aes_final_round.sv
module aes_final_round (
  input  logic            clk,
  input  aes_pkg::block_t state_in,
  input  aes_pkg::block_t round_key,
  output aes_pkg::block_t state_out
);

  import aes_pkg::*;

  word_t sub [4];
  word_t shifted [4];

  for (genvar c = 0; c < 4; c++)
  begin : g_col
    aes_sub_word sub_word_i (
      .clk      (clk),
      .word_in  (state_in[127-32*c -: 32]),
      .word_out (sub[c])
    );
  end

  // ShiftRows only; no MixColumns in the last round.
  always_comb
  begin
    for (int c = 0; c < 4; c++)
    begin
      for (int r = 0; r < 4; r++)
      begin
        shifted[c][31-8*r -: 8] = sub[(c + r) % 4][31-8*r -: 8];
      end
    end
  end

  always_ff @(posedge clk)
  begin
    state_out <= {shifted[0], shifted[1], shifted[2], shifted[3]} ^ round_key;
  end

endmodule

//--- cipher_round/aes_round.sv
module aes_round (
  input  logic            clk,
  input  aes_pkg::block_t state_in,
  input  aes_pkg::block_t round_key,
  output aes_pkg::block_t state_out
);

  import aes_pkg::*;

  word_t prod [4][4];
  word_t mixed [4];

  for (genvar c = 0; c < 4; c++)
  begin : g_col
    aes_ttable_column column_i (
      .clk    (clk),
      .column (state_in[127-32*c -: 32]),
      .p0     (prod[c][0]),
      .p1     (prod[c][1]),
      .p2     (prod[c][2]),
      .p3     (prod[c][3])
    );
  end

  // row r of output column c comes from input column c+r (ShiftRows).
  always_comb
  begin
    for (int c = 0; c < 4; c++)
    begin
      mixed[c] = round_key[127-32*c -: 32];
      for (int r = 0; r < 4; r++)
      begin
        mixed[c] = mixed[c] ^ prod[(c + r) % 4][r];
      end
    end
  end

  always_ff @(posedge clk)
  begin
    state_out <= {mixed[0], mixed[1], mixed[2], mixed[3]};
  end

endmodule

//--- cipher_round/aes_ttable_column.sv
module aes_ttable_column (
  input  logic           clk,
  input  aes_pkg::word_t column,
  output aes_pkg::word_t p0,
  output aes_pkg::word_t p1,
  output aes_pkg::word_t p2,
  output aes_pkg::word_t p3
);

  import aes_pkg::*;

  byte_t s_q [4];
  byte_t d_q [4];
  word_t prod [4];

  // byte 0 is the top byte of the column, i.e. row 0.
  always_ff @(posedge clk)
  begin
    for (int i = 0; i < 4; i++)
    begin
      s_q[i] <= SBOX[column[31-8*i -: 8]];
      d_q[i] <= xtime(SBOX[column[31-8*i -: 8]]);
    end
  end

  // MixColumns coefficients 1, 1, 3, 2 for each substituted byte.
  always_comb
  begin
    for (int i = 0; i < 4; i++)
    begin
      prod[i] = {s_q[i], s_q[i], s_q[i] ^ d_q[i], d_q[i]};
    end
  end

  // rotate so the 2s term lands on the row that the byte came from.
  assign p0 = {prod[0][7:0], prod[0][31:8]};
  assign p1 = {prod[1][15:0], prod[1][31:16]};
  assign p2 = {prod[2][23:0], prod[2][31:24]};
  assign p3 = prod[3];

endmodule

//--- common/aes_pkg.sv
package aes_pkg;

  typedef logic [7:0]   byte_t;
  typedef logic [31:0]  word_t;
  typedef logic [127:0] block_t;

  localparam int NUM_ROUNDS = 10;

  // whitening register plus two registers per round.
  localparam int CORE_LATENCY = 1 + 2 * NUM_ROUNDS;

  localparam byte_t SBOX [256] = '{
    8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
    8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
    8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
    8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
    8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
    8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
    8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
    8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
    8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
    8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
    8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
    8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
    8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
    8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
    8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
    8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
    8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
    8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
    8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
    8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
    8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
    8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
    8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
    8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
    8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
    8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
    8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
    8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
    8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
    8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
    8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
    8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
  };

  // round constants for key schedule steps 1 to 10.
  localparam byte_t RCON [10] = '{
    8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
    8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
  };

  // multiply by x modulo the AES polynomial x^8 + x^4 + x^3 + x + 1.
  function automatic byte_t xtime(input byte_t b);
    byte_t shifted;
    shifted = {b[6:0], 1'b0};
    if (b[7])
    begin
      shifted = shifted ^ 8'h1b;
    end
    return shifted;
  endfunction

endpackage

//--- dv/aes_model.svh
`ifndef AES_MODEL_SVH
`define AES_MODEL_SVH

// byte i of a block is row i % 4 of column i / 4, counted from the top byte.
function automatic block_t aes_encrypt(input block_t pt, input block_t cipher_key);
  byte_t s [16];
  byte_t t [16];
  byte_t rk [16];
  byte_t tmp [4];
  byte_t a [4];
  block_t result;
  for (int i = 0; i < 16; i++)
  begin
    rk[i] = cipher_key[127-8*i -: 8];
    s[i] = pt[127-8*i -: 8] ^ rk[i];
  end
  for (int round = 1; round <= 10; round++)
  begin
    tmp[0] = SBOX[rk[13]] ^ RCON[round-1]; // RotWord then SubWord on the last word.
    tmp[1] = SBOX[rk[14]];
    tmp[2] = SBOX[rk[15]];
    tmp[3] = SBOX[rk[12]];
    for (int i = 0; i < 16; i++)
    begin
      if (i < 4)
        rk[i] = rk[i] ^ tmp[i];
      else
        rk[i] = rk[i] ^ rk[i-4];
    end
    for (int i = 0; i < 16; i++)
    begin
      s[i] = SBOX[s[i]];
    end
    for (int c = 0; c < 4; c++)
    begin
      for (int r = 0; r < 4; r++)
      begin
        t[r+4*c] = s[r+4*((c+r)%4)]; // row r moves left by r columns.
      end
    end
    for (int c = 0; c < 4; c++)
    begin
      for (int r = 0; r < 4; r++)
      begin
        a[r] = t[r+4*c];
      end
      if (round < 10)
      begin
        s[4*c]   = xtime(a[0]) ^ xtime(a[1]) ^ a[1] ^ a[2] ^ a[3];
        s[4*c+1] = a[0] ^ xtime(a[1]) ^ xtime(a[2]) ^ a[2] ^ a[3];
        s[4*c+2] = a[0] ^ a[1] ^ xtime(a[2]) ^ xtime(a[3]) ^ a[3];
        s[4*c+3] = xtime(a[0]) ^ a[0] ^ a[1] ^ a[2] ^ xtime(a[3]);
      end
      else
      begin
        for (int r = 0; r < 4; r++)
        begin
          s[r+4*c] = a[r]; // the last round skips MixColumns.
        end
      end
    end
    for (int i = 0; i < 16; i++)
    begin
      s[i] = s[i] ^ rk[i];
    end
  end
  for (int i = 0; i < 16; i++)
  begin
    result[127-8*i -: 8] = s[i];
  end
  return result;
endfunction

`endif

//--- dv/aes_128_tb.sv
module aes_128_tb;

  import aes_pkg::*;

  `include "aes_model.svh"

  localparam int RESET_CYCLES = 3;
  localparam int STREAM_LEN = 200;
  localparam int GAP_LEN = 300;
  localparam int IDLE_LEN = CORE_LATENCY + 4;
  localparam int PRE_RESET_LEN = 40;
  localparam int POST_RESET_LEN = 30;
  localparam int VARIANT_LEN = 260;
  localparam int DRAIN_LEN = CORE_LATENCY + 3;
  localparam int PLANNED_CYCLES = 2 * RESET_CYCLES + 1 + STREAM_LEN + GAP_LEN + IDLE_LEN
    + PRE_RESET_LEN + RESET_CYCLES + POST_RESET_LEN + VARIANT_LEN + 6 * DRAIN_LEN;
  localparam int WATCHDOG_CYCLES = PLANNED_CYCLES + CORE_LATENCY + 100;

  logic clk;
  logic rst;
  logic in_valid;
  block_t plaintext;
  block_t key;
  logic out_valid;
  block_t ciphertext;

  block_t exp_q [$];
  int due_q [$]; // cycle at which each expected block must appear.
  int cycle;
  logic checks_on;

  aes_128_core aes_128_core_i (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .plaintext  (plaintext),
    .key        (key),
    .out_valid  (out_valid),
    .ciphertext (ciphertext)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Test failures found");
    $fatal(1, "stopped at the first error");
  endtask

  function automatic block_t random_block();
    return {$urandom(), $urandom(), $urandom(), $urandom()};
  endfunction

  // an input only counts when the next rising edge sees rst low.
  task automatic drive(input logic valid, input block_t pt, input block_t k);
    in_valid = valid;
    plaintext = pt;
    key = k;
    if (valid && !rst)
    begin
      exp_q.push_back(aes_encrypt(pt, k));
      due_q.push_back(cycle + CORE_LATENCY);
    end
  endtask

  task automatic send(input logic valid, input block_t pt, input block_t k);
    @(negedge clk);
    drive(valid, pt, k);
  endtask

  task automatic drain();
    send(1'b0, '0, '0);
    while (due_q.size() != 0)
    begin
      @(negedge clk);
    end
  endtask

  task automatic apply_reset();
    @(negedge clk);
    rst = 1'b1;
    in_valid = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
  endtask

  // outputs are read before this edge updates them.
  always @(posedge clk)
  begin
    logic due_now;
    due_now = (due_q.size() != 0) && (due_q[0] == cycle);
    if (checks_on)
    begin
      assert (out_valid === due_now)
      else report_failure($sformatf("mismatch at %0t: out_valid got %b expected %b",
                                    $time, out_valid, due_now));
      if (due_now)
      begin
        assert (ciphertext === exp_q[0])
        else report_failure($sformatf("mismatch at %0t: ciphertext got %h expected %h",
                                      $time, ciphertext, exp_q[0]));
        void'(exp_q.pop_front());
        void'(due_q.pop_front());
      end
    end
    if (rst)
    begin
      exp_q.delete(); // blocks in flight are dropped by the reset.
      due_q.delete();
      checks_on = 1'b1;
    end
    cycle++;
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    report_failure("timeout: the tests did not finish within the expected number of cycles");
  end

  initial
  begin
    block_t fixed_key;
    block_t fixed_pt;
    void'($urandom(11297));
    cycle = 0;
    checks_on = 1'b0;
    rst = 1'b1;
    in_valid = 1'b0;
    plaintext = '0;
    key = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    fixed_key = 128'h2b7e151628aed2a6abf7158809cf4f3c;
    fixed_pt = 128'h3243f6a8885a308d313198a2e0370734;
    assert (aes_encrypt(fixed_pt, fixed_key) == 128'h3925841d02dc09fbdc118597196a0b32)
    else report_failure("the reference model does not reproduce the FIPS-197 example");
    send(1'b1, fixed_pt, fixed_key);
    drain();

    for (int i = 0; i < STREAM_LEN; i++)
    begin
      send(1'b1, random_block(), random_block());
    end
    drain();

    for (int i = 0; i < GAP_LEN; i++)
    begin
      send(($urandom() % 2) == 1, random_block(), random_block());
    end
    drain();

    apply_reset();
    repeat (IDLE_LEN) send(1'b0, random_block(), random_block());
    for (int i = 0; i < PRE_RESET_LEN; i++)
    begin
      send(1'b1, random_block(), random_block());
    end
    for (int i = 0; i < RESET_CYCLES; i++)
    begin
      @(negedge clk);
      rst = 1'b1;
      drive(1'b1, random_block(), random_block());
    end
    @(negedge clk);
    rst = 1'b0;
    drive(1'b1, random_block(), random_block());
    for (int i = 1; i < POST_RESET_LEN; i++)
    begin
      send(1'b1, random_block(), random_block());
    end
    drain();

    fixed_key = 128'h000102030405060708090a0b0c0d0e0f;
    send(1'b1, '0, fixed_key);
    send(1'b1, '1, fixed_key);
    for (int i = 0; i < 128; i++)
    begin
      send(1'b1, 128'd1 << i, fixed_key);
    end
    fixed_pt = 128'h00112233445566778899aabbccddeeff;
    send(1'b1, fixed_pt, '0);
    send(1'b1, fixed_pt, '1);
    for (int i = 0; i < 128; i++)
    begin
      send(1'b1, fixed_pt, 128'd1 << i);
    end
    drain();

    $display("All tests passed!");
    $finish;
  end

endmodule

//--- key_schedule/aes_key_expand.sv
module aes_key_expand (
  input  logic            clk,
  input  aes_pkg::block_t key_in,
  input  aes_pkg::byte_t  rcon,
  output aes_pkg::block_t round_key,
  output aes_pkg::block_t key_out
);

  import aes_pkg::*;

  word_t w [4];
  word_t prefix [4];
  word_t prefix_q [4];
  word_t sub_rot;

  always_comb
  begin
    for (int i = 0; i < 4; i++)
    begin
      w[i] = key_in[127-32*i -: 32];
    end
    // rcon only touches the top byte of word 0.
    prefix[0] = {w[0][31:24] ^ rcon, w[0][23:0]};
    for (int i = 1; i < 4; i++)
    begin
      prefix[i] = prefix[i-1] ^ w[i];
    end
  end

  always_ff @(posedge clk)
  begin
    prefix_q <= prefix;
  end

  // the substituted word SubWord(RotWord(w3)) lines up with prefix_q.
  aes_sub_word sub_word_i (
    .clk      (clk),
    .word_in  ({w[3][23:0], w[3][31:24]}),
    .word_out (sub_rot)
  );

  // every new word is its prefix XOR plus the same substituted word.
  always_comb
  begin
    for (int i = 0; i < 4; i++)
    begin
      round_key[127-32*i -: 32] = prefix_q[i] ^ sub_rot;
    end
  end

  always_ff @(posedge clk)
  begin
    key_out <= round_key; // next stage sees it with the next round's state.
  end

endmodule

//--- list.f
+incdir+dv
common/aes_pkg.sv
src/aes_sub_word.sv
cipher_round/aes_ttable_column.sv
cipher_round/aes_round.sv
cipher_round/aes_final_round.sv
key_schedule/aes_key_expand.sv
src/aes_128_core.sv
dv/aes_128_tb.sv

//--- src/aes_128_core.sv
module aes_128_core (
  input  logic            clk,
  input  logic            rst,
  input  logic            in_valid,
  input  aes_pkg::block_t plaintext,
  input  aes_pkg::block_t key,
  output logic            out_valid,
  output aes_pkg::block_t ciphertext
);

  import aes_pkg::*;

  block_t whiten_q;
  block_t key_q;
  block_t state [NUM_ROUNDS];
  block_t key_chain [NUM_ROUNDS];
  block_t round_key [NUM_ROUNDS];
  logic [CORE_LATENCY-1:0] valid_sr;

  // initial AddRoundKey with the cipher key itself.
  always_ff @(posedge clk)
  begin
    whiten_q <= plaintext ^ key;
    key_q <= key;
  end

  assign state[0] = whiten_q;
  assign key_chain[0] = key_q;

  for (genvar i = 0; i < NUM_ROUNDS; i++)
  begin : g_key
    if (i < NUM_ROUNDS - 1)
    begin : g_mid
      aes_key_expand key_expand_i (
        .clk       (clk),
        .key_in    (key_chain[i]),
        .rcon      (RCON[i]),
        .round_key (round_key[i]),
        .key_out   (key_chain[i+1])
      );
    end
    else
    begin : g_last
      // nothing follows the last step, so its key_out stays open.
      aes_key_expand key_expand_i (
        .clk       (clk),
        .key_in    (key_chain[i]),
        .rcon      (RCON[i]),
        .round_key (round_key[i]),
        .key_out   ()
      );
    end
  end

  for (genvar i = 0; i < NUM_ROUNDS - 1; i++)
  begin : g_round
    aes_round round_i (
      .clk       (clk),
      .state_in  (state[i]),
      .round_key (round_key[i]),
      .state_out (state[i+1])
    );
  end

  aes_final_round final_round_i (
    .clk       (clk),
    .state_in  (state[NUM_ROUNDS-1]),
    .round_key (round_key[NUM_ROUNDS-1]),
    .state_out (ciphertext)
  );

  // one bit per register stage of the datapath.
  always_ff @(posedge clk)
  begin
    if (rst)
      valid_sr <= '0;
    else
      valid_sr <= {valid_sr[CORE_LATENCY-2:0], in_valid};
  end

  assign out_valid = valid_sr[CORE_LATENCY-1];

endmodule

//--- src/aes_sub_word.sv
module aes_sub_word (
  input  logic           clk,
  input  aes_pkg::word_t word_in,
  output aes_pkg::word_t word_out
);

  import aes_pkg::*;

  // each byte goes through its own S-box lookup, registered.
  always_ff @(posedge clk)
  begin
    for (int i = 0; i < 4; i++)
    begin
      word_out[8*i +: 8] <= SBOX[word_in[8*i +: 8]];
    end
  end

endmodule
